//--- project.f
src/image_geom_pkg.sv
src/blur_ctrl_pkg.sv
src/row_stream_if.sv
src/image_row_mem.sv
src/blur_sequencer.sv
src/gaussian_row_filter.sv
src/blur_row_output.sv
src/blur_core.sv
verification/blur_core_properties.sv
verification/blur_core_checker.sv
verification/blur_core_tb.sv

//--- verification/blur_input.txt
// one 64-bit row per line, hex, column 7 on the left and column 0 in the low byte
// per image: 8 source rows, then its 8 expected blurred rows
// image one source, pixel = (row+1)*(col+1)
0807060504030201
100e0c0a08060402
1815120f0c090603
201c1814100c0804
28231e19140f0a05
302a241e18120c06
38312a231c150e07
4038302820181008
// image one expected
0507060504030201
0b0e0c0a08060402
1115120f0c090603
171c1814100c0804
1c231e19140f0a05
222a241e18120c06
28312a231c150e07
2128221c17110b05
// image two source, all ff with a zero at row 3 column 4
ffffffffffffffff
ffffffffffffffff
ffffffffffffffff
ffffff00ffffffff
ffffffffffffffff
ffffffffffffffff
ffffffffffffffff
ffffffffffffffff
// image two expected
8fbfbfbfbfbfbf8f
bfffffffffffffbf
bfffefdfefffffbf
bfffdfbfdfffffbf
bfffefdfefffffbf
bfffffffffffffbf
bfffffffffffffbf
8fbfbfbfbfbfbf8f

//--- verification/blur_core_tb.sv
`timescale 1ns/1ps
module blur_core_tb;

    localparam int OUT_DEPTH    = 4;                 // output FIFO rows
    localparam int CREDITS      = 2;                 // consumer credits
    localparam int SEED         = 32'h5ce5;
    localparam int ROW_TIMEOUT  = 200;               // cycles allowed per row
    localparam int DONE_TIMEOUT = 20;
    localparam int NUM_VECS     = 4 * image_geom_pkg::IMG_ROWS;
    localparam     DATA_FILE    = "verification/blur_input.txt";

    logic                      clk;
    logic                      rst_n;
    logic                      img_we;
    image_geom_pkg::row_addr_t img_addr;
    image_geom_pkg::row_t      img_din;
    logic                      start;
    logic                      done;
    logic                      out_valid;
    image_geom_pkg::row_addr_t out_row_idx;
    image_geom_pkg::row_t      out_row;
    logic                      out_credit;

    image_geom_pkg::row_t [image_geom_pkg::IMG_ROWS-1:0] exp_rows; // rows of the current run
    image_geom_pkg::row_t vec_mem [NUM_VECS];        // source and expected rows, both images
    int                   run_id;
    int                   chk_errors;
    int                   timeouts;

    blur_core #(.OUT_DEPTH(OUT_DEPTH), .CREDITS(CREDITS)) i_blur_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .img_we      (img_we),
        .img_addr    (img_addr),
        .img_din     (img_din),
        .start       (start),
        .done        (done),
        .out_valid   (out_valid),
        .out_row_idx (out_row_idx),
        .out_row     (out_row),
        .out_credit  (out_credit)
    );

    blur_core_checker #(.CREDITS(CREDITS)) i_blur_core_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .done        (done),
        .out_valid   (out_valid),
        .out_row_idx (out_row_idx),
        .out_row     (out_row),
        .out_credit  (out_credit),
        .exp_rows    (exp_rows),
        .run_id      (run_id),
        .errors      (chk_errors)
    );

    bind blur_row_output blur_core_properties #(
        .CREDITS (CREDITS),
        .CRED_W  (CRED_W),
        .CNT_W   (CNT_W)
    ) i_blur_core_properties (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (stream.valid),
        .out_valid   (out_valid),
        .done        (done),
        .ext_credits (ext_credits)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #5 clk = ~clk;                       // 10 ns period
    end

    // consumer side, acks each row after 0..6 cycles
    initial begin : credit_return
        integer seed;
        int     pending;                             // rows held, not acked
        int     hold;                                // cycles before the next ack
        seed       = SEED;
        pending    = 0;
        out_credit = 1'b0;
        hold       = $unsigned($random(seed)) % 7;
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (out_valid) begin
                pending++;
            end
            if (pending > 0) begin
                if (hold == 0) begin
                    out_credit = 1'b1;
                    pending--;
                    hold = $unsigned($random(seed)) % 7;
                end else begin
                    hold--;                          // withheld, FIFO backs up
                end
            end
        end
    end

    task automatic wait_row(input int row, input string name);
        int cycles;
        cycles = 0;
        while (!out_valid && cycles < ROW_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            $display("timeout: row %0d of %s did not arrive in %0d cycles", row, name, ROW_TIMEOUT);
            timeouts++;
        end else begin
            @(negedge clk);                          // step past this row
        end
    endtask

    task automatic wait_done(input logic level, input string name);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== level) begin
            $display("timeout: done did not go to %0b during %s", level, name);
            timeouts++;
        end
    endtask

    // load one image, start it and follow its rows to done
    task automatic run_image(input int id, input int base, input string name);
        for (int r = 0; r < image_geom_pkg::IMG_ROWS; r++) begin
            @(negedge clk);
            img_we      = 1'b1;
            img_addr    = image_geom_pkg::row_addr_t'(r);
            img_din     = vec_mem[base + r];
            exp_rows[r] = vec_mem[base + image_geom_pkg::IMG_ROWS + r];
        end
        @(negedge clk);
        img_we = 1'b0;
        run_id = id;
        start  = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done(1'b0, name);                       // a rerun clears done first
        for (int r = 0; r < image_geom_pkg::IMG_ROWS; r++) begin
            wait_row(r, name);
        end
        wait_done(1'b1, name);
    endtask

    initial begin : main
        rst_n    = 1'b0;
        img_we   = 1'b0;
        img_addr = '0;
        img_din  = '0;
        start    = 1'b0;
        run_id   = 0;
        exp_rows = '0;
        timeouts = 0;
        $readmemh(DATA_FILE, vec_mem);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);                  // idle, no row may show up
        run_image(1, 0, "image_one");
        repeat (5) @(negedge clk);
        run_image(2, 2 * image_geom_pkg::IMG_ROWS, "image_two");
        repeat (10) @(negedge clk);                  // let the last acks come back
        $display("checker errors: %0d, timeouts: %0d", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verification/blur_core_checker.sv
`timescale 1ns/1ps
module blur_core_checker #(
    parameter int CREDITS = 2                        // rows the consumer may hold
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      done,
    input  logic                      out_valid,
    input  image_geom_pkg::row_addr_t out_row_idx,
    input  image_geom_pkg::row_t      out_row,
    input  logic                      out_credit,
    input  image_geom_pkg::row_t [image_geom_pkg::IMG_ROWS-1:0] exp_rows,
    input  int                        run_id,        // which image is running
    output int                        errors
);

    int   err_cnt = 0;
    int   rows_seen;                                 // rows checked in this run
    int   outstanding;                               // rows sent, not acked yet
    logic armed;                                     // a start has been seen
    logic in_reset;
    logic row7_sent;                                 // last row went out last cycle
    logic done_q;
    logic start_q;

    assign errors = err_cnt;

    function automatic string test_name(input int id);
        case (id)
            1:       return "image_one";
            2:       return "image_two";
            default: return "no_run";
        endcase
    endfunction

    always @(posedge clk) begin : compare
        int next_out;
        if (!rst_n) begin
            armed       <= 1'b0;
            in_reset    <= 1'b1;
            row7_sent   <= 1'b0;
            done_q      <= 1'b0;
            start_q     <= 1'b0;
            rows_seen   <= 0;
            outstanding <= 0;
        end else begin
            in_reset  <= 1'b0;
            done_q    <= done;
            start_q   <= start;
            row7_sent <= out_valid &&
                         (out_row_idx == image_geom_pkg::row_addr_t'(image_geom_pkg::IMG_ROWS - 1));
            if (in_reset && (out_valid || done)) begin
                $display("out_valid or done was high right after reset");
                err_cnt++;
            end
            next_out = outstanding + int'(out_valid) - int'(out_credit); // consumer's view
            if (next_out > CREDITS) begin
                $display("consumer holds %0d rows, more than its %0d credits", next_out, CREDITS);
                err_cnt++;
            end
            outstanding <= next_out;
            if (out_valid) begin
                if (!armed || rows_seen >= image_geom_pkg::IMG_ROWS) begin
                    $display("row %0d came out while no run expected it", out_row_idx);
                    err_cnt++;
                end else begin
                    if (int'(out_row_idx) != rows_seen) begin
                        $display("[ERROR] %s row index: expected %0d actual %0d",
                                 test_name(run_id), rows_seen, out_row_idx);
                        err_cnt++;
                    end
                    if (out_row !== exp_rows[rows_seen]) begin
                        $display("[ERROR] %s row %0d data: expected %h actual %h",
                                 test_name(run_id), rows_seen, exp_rows[rows_seen], out_row);
                        err_cnt++;
                    end
                    rows_seen <= rows_seen + 1;
                end
            end
            if (row7_sent && !done) begin
                $display("done did not rise after row 7 of %s", test_name(run_id));
                err_cnt++;
            end
            if (done_q && !done && !start_q) begin
                $display("done fell with no start");
                err_cnt++;
            end
            if (start_q && done) begin
                $display("done still high after start of %s", test_name(run_id));
                err_cnt++;
            end
            if (done && !done_q && rows_seen != image_geom_pkg::IMG_ROWS) begin
                $display("%s finished after %0d rows", test_name(run_id), rows_seen);
                err_cnt++;
            end
            if (start) begin
                armed     <= 1'b1;                   // new run, count from row 0
                rows_seen <= 0;
            end
        end
    end

endmodule

//--- verification/blur_core_properties.sv
`timescale 1ns/1ps
module blur_core_properties #(
    parameter int CREDITS = 2,                       // consumer credits after reset
    parameter int CRED_W  = 2,                       // width of the credit counter
    parameter int CNT_W   = 3                        // width of the FIFO count
) (
    input logic              clk,
    input logic              rst_n,
    input logic              push,                   // filter row written into the FIFO
    input logic              out_valid,
    input logic              done,
    input logic [CRED_W-1:0] ext_credits
);

    logic [CNT_W-1:0] rows_held;                     // own tally of rows in the FIFO

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rows_held <= '0;
        end else begin
            rows_held <= rows_held + CNT_W'(push) - CNT_W'(out_valid);
        end
    end

    // acks can never push the counter past its start value
    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        ext_credits <= CRED_W'(CREDITS))
        else $error("external credit counter above %0d", CREDITS);

    // a row only goes out of a FIFO that holds one
    valid_has_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (rows_held != '0))
        else $error("out_valid high with an empty output FIFO");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !done))            // outputs quiet once reset has hit
        else $error("out_valid or done high in the cycle after reset");

endmodule

//--- src/blur_core.sv
`timescale 1ns/1ps
module blur_core #(
    parameter int OUT_DEPTH = 4,                     // output FIFO rows
    parameter int CREDITS   = 2                      // consumer credits
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      img_we,        // load port
    input  image_geom_pkg::row_addr_t img_addr,
    input  image_geom_pkg::row_t      img_din,
    input  logic                      start,         // one-cycle pulse
    output logic                      done,          // level until next start
    output logic                      out_valid,     // row stream
    output image_geom_pkg::row_addr_t out_row_idx,
    output image_geom_pkg::row_t      out_row,
    input  logic                      out_credit     // one credit back per pulse
);

    logic                      mem_we;
    image_geom_pkg::row_addr_t mem_addr;
    image_geom_pkg::row_t      mem_dout;
    logic                      row_in_valid;
    logic                      fill_zero;

    row_stream_if i_stream ();                       // filter -> output, credits -> sequencer

    image_row_mem i_image_row_mem (
        .clk  (clk),
        .we   (mem_we),
        .addr (mem_addr),
        .din  (img_din),
        .dout (mem_dout)
    );

    blur_sequencer #(.OUT_DEPTH(OUT_DEPTH)) i_blur_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .img_we       (img_we),
        .img_addr     (img_addr),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .row_in_valid (row_in_valid),
        .fill_zero    (fill_zero),
        .stream       (i_stream.credit_sink)
    );

    gaussian_row_filter i_gaussian_row_filter (
        .clk          (clk),
        .rst_n        (rst_n),
        .row_in_valid (row_in_valid),
        .fill_zero    (fill_zero),
        .row_in       (mem_dout),
        .stream       (i_stream.producer)
    );

    blur_row_output #(.OUT_DEPTH(OUT_DEPTH), .CREDITS(CREDITS)) i_blur_row_output (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_row_idx (out_row_idx),
        .out_row     (out_row),
        .done        (done),
        .stream      (i_stream.consumer)
    );

endmodule

//--- src/blur_row_output.sv
`timescale 1ns/1ps
module blur_row_output #(
    parameter int OUT_DEPTH = 4,                     // FIFO rows
    parameter int CREDITS   = 2                      // consumer credits after reset
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      out_credit,
    output logic                      out_valid,
    output image_geom_pkg::row_addr_t out_row_idx,
    output image_geom_pkg::row_t      out_row,
    output logic                      done,
    row_stream_if.consumer            stream
);

    localparam int PTR_W  = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W  = $clog2(OUT_DEPTH + 1);
    localparam int CRED_W = $clog2(CREDITS + 1);

    image_geom_pkg::row_t      row_mem [OUT_DEPTH];  // FIFO payload
    image_geom_pkg::row_addr_t idx_mem [OUT_DEPTH];  // row index per entry
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          fifo_count;           // rows held
    logic [CRED_W-1:0]         ext_credits;          // consumer credits left
    logic                      pop;

    // one row leaves per cycle while credit and data are both there
    assign pop         = (ext_credits != '0) && (fifo_count != '0);
    assign out_valid   = pop;
    assign out_row     = row_mem[rd_ptr];            // head of the FIFO
    assign out_row_idx = idx_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (stream.valid) begin
            row_mem[wr_ptr] <= stream.data;          // room is guaranteed upstream
            idx_mem[wr_ptr] <= stream.row_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            fifo_count    <= '0;
            ext_credits   <= CRED_W'(CREDITS);
            stream.credit <= 1'b0;
            done          <= 1'b0;
        end else begin
            stream.credit <= pop;                    // hand the slot back to the sequencer
            if (stream.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({stream.valid, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
            case ({pop, out_credit})
                2'b10:   ext_credits <= ext_credits - 1'b1; // row sent
                2'b01:   ext_credits <= ext_credits + 1'b1; // consumer acked
                default: ext_credits <= ext_credits;
            endcase
            // done after the last row goes out, held until the next run
            if (start) begin
                done <= 1'b0;
            end else if (pop && (out_row_idx ==
                         image_geom_pkg::row_addr_t'(image_geom_pkg::IMG_ROWS - 1))) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- src/gaussian_row_filter.sv
`timescale 1ns/1ps
module gaussian_row_filter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 row_in_valid,
    input  logic                 fill_zero,
    input  image_geom_pkg::row_t row_in,
    row_stream_if.producer       stream
);

    localparam int CNT_W = $clog2(image_geom_pkg::IMG_ROWS + 1);

    logic [CNT_W-1:0]     slot_cnt;                  // slots seen in this run, 0..8
    image_geom_pkg::row_t above_row;                 // row r-1
    image_geom_pkg::row_t centre_row;                // row r, the one being blurred
    image_geom_pkg::row_t below_row;                 // row r+1, arriving now
    image_geom_pkg::row_t blurred;                   // kernel result for centre_row

    // 1-2-1 across the columns of one row, zero past the edges
    function automatic blur_ctrl_pkg::sum_t h_sum(
        input image_geom_pkg::row_t r,
        input int                   c
    );
        blur_ctrl_pkg::sum_t acc;
        acc = blur_ctrl_pkg::sum_t'(r[c*image_geom_pkg::PIX_W +: image_geom_pkg::PIX_W]) << 1;
        if (c > 0) begin
            acc = acc + blur_ctrl_pkg::sum_t'(
                r[(c-1)*image_geom_pkg::PIX_W +: image_geom_pkg::PIX_W]);  // left
        end
        if (c < image_geom_pkg::IMG_COLS - 1) begin
            acc = acc + blur_ctrl_pkg::sum_t'(
                r[(c+1)*image_geom_pkg::PIX_W +: image_geom_pkg::PIX_W]);  // right
        end
        return acc;
    endfunction

    // flush slot brings a zero row below row 7
    assign below_row = fill_zero ? '0 : row_in;

    // vertical 1-2-1 over the three horizontal sums
    always_comb begin
        blur_ctrl_pkg::sum_t acc;
        blurred = '0;
        for (int c = 0; c < image_geom_pkg::IMG_COLS; c++) begin
            acc = h_sum(above_row, c)
                + (h_sum(centre_row, c) << 1)
                + h_sum(below_row, c);
            blurred[c*image_geom_pkg::PIX_W +: image_geom_pkg::PIX_W] =
                image_geom_pkg::pixel_t'(acc >> blur_ctrl_pkg::KERNEL_SHIFT); // truncating
        end
    end

    // slot counter and output strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_cnt     <= '0;
            stream.valid <= 1'b0;
        end else begin
            stream.valid <= row_in_valid && (slot_cnt != '0); // first slot only primes
            if (row_in_valid) begin
                if (slot_cnt == CNT_W'(image_geom_pkg::IMG_ROWS)) begin
                    slot_cnt <= '0;                  // ninth slot ends the run
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    // line buffer shift and result row
    always_ff @(posedge clk) begin
        if (row_in_valid) begin
            above_row      <= (slot_cnt == '0) ? '0 : centre_row; // zero above row 0
            centre_row     <= below_row;
            stream.data    <= blurred;
            stream.row_idx <= image_geom_pkg::row_addr_t'(slot_cnt - 1'b1);
        end
    end

endmodule

//--- src/blur_sequencer.sv
`timescale 1ns/1ps
module blur_sequencer #(
    parameter int OUT_DEPTH = 4                      // credits at the start of a run
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      img_we,
    input  image_geom_pkg::row_addr_t img_addr,
    output logic                      mem_we,
    output image_geom_pkg::row_addr_t mem_addr,
    output logic                      row_in_valid,
    output logic                      fill_zero,
    row_stream_if.credit_sink         stream
);

    localparam int CRED_W = $clog2(OUT_DEPTH + 1);

    blur_ctrl_pkg::seq_state_t state;
    image_geom_pkg::row_addr_t rd_row;               // next row to read
    logic [CRED_W-1:0]         credits;              // free FIFO slots downstream
    logic                      slot_go;              // a slot leaves this cycle
    logic                      spend;                // slot that will make an output row
    logic                      last_row;

    assign last_row = (rd_row == image_geom_pkg::row_addr_t'(image_geom_pkg::IMG_ROWS - 1));
    assign slot_go  = (state != blur_ctrl_pkg::SEQ_IDLE) && (credits != '0);

    // row 0 only primes the line buffer, no row comes out of it
    assign spend = slot_go && !((state == blur_ctrl_pkg::SEQ_READ) && (rd_row == '0));

    // load port owns the memory while idle or done
    assign mem_we   = img_we && (state == blur_ctrl_pkg::SEQ_IDLE);
    assign mem_addr = (state == blur_ctrl_pkg::SEQ_IDLE) ? img_addr : rd_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= blur_ctrl_pkg::SEQ_IDLE;
            rd_row  <= '0;
            credits <= CRED_W'(OUT_DEPTH);
        end else begin
            case (state)
                blur_ctrl_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state   <= blur_ctrl_pkg::SEQ_READ;
                        rd_row  <= '0;
                        credits <= CRED_W'(OUT_DEPTH); // fresh run, FIFO drained
                    end
                end
                blur_ctrl_pkg::SEQ_READ: begin
                    if (slot_go) begin
                        if (last_row) begin
                            state <= blur_ctrl_pkg::SEQ_FLUSH;
                        end else begin
                            rd_row <= rd_row + 1'b1;
                        end
                    end
                end
                blur_ctrl_pkg::SEQ_FLUSH: begin
                    if (slot_go) begin
                        state <= blur_ctrl_pkg::SEQ_IDLE; // flush slot sent
                    end
                end
                default: state <= blur_ctrl_pkg::SEQ_IDLE;
            endcase

            if (state != blur_ctrl_pkg::SEQ_IDLE) begin
                case ({spend, stream.credit})
                    2'b10:   credits <= credits - 1'b1; // slot out, none back
                    2'b01:   credits <= credits + 1'b1; // pop returned one
                    default: credits <= credits;        // both or neither
                endcase
            end else if (!start && stream.credit) begin
                credits <= credits + 1'b1;              // late return after the flush
            end
        end
    end

    // strobe delayed to line up with the memory read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_in_valid <= 1'b0;
            fill_zero    <= 1'b0;
        end else begin
            row_in_valid <= slot_go;
            fill_zero    <= slot_go && (state == blur_ctrl_pkg::SEQ_FLUSH);
        end
    end

endmodule

//--- src/image_row_mem.sv
`timescale 1ns/1ps
module image_row_mem (
    input  logic                      clk,
    input  logic                      we,
    input  image_geom_pkg::row_addr_t addr,
    input  image_geom_pkg::row_t      din,
    output image_geom_pkg::row_t      dout
);

    image_geom_pkg::row_t mem [image_geom_pkg::IMG_ROWS]; // one word per image row

    // single port, write has priority over the read data
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;                        // load port
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

//--- src/row_stream_if.sv
`timescale 1ns/1ps
interface row_stream_if;

    logic                      valid;                // blurred row valid, one cycle
    image_geom_pkg::row_addr_t row_idx;              // index of the blurred row
    image_geom_pkg::row_t      data;                 // blurred row payload
    logic                      credit;               // one pulse per FIFO pop

    // filter side
    modport producer (
        output valid, row_idx, data
    );

    // output stage side
    modport consumer (
        input  valid, row_idx, data,
        output credit
    );

    // sequencer only watches returned credits
    modport credit_sink (
        input credit
    );

endinterface

//--- src/blur_ctrl_pkg.sv
package blur_ctrl_pkg;

    // sequencer FSM states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,                            // waiting for start
        SEQ_READ  = 2'd1,                            // reading rows 0..7
        SEQ_FLUSH = 2'd2                             // zero row below the last one
    } seq_state_t;

    // 1-2-1 x 1-2-1 weights add up to 16
    parameter int KERNEL_SHIFT = 4;

    // worst case 16 * 255 = 4080, fits 12 bits
    typedef logic [11:0] sum_t;

endpackage

//--- src/image_geom_pkg.sv
package image_geom_pkg;

    parameter int IMG_ROWS = 8;                      // image height
    parameter int IMG_COLS = 8;                      // image width
    parameter int PIX_W    = 8;                      // bits per pixel

    typedef logic [PIX_W-1:0] pixel_t;

    // full row, column 0 sits in the low byte
    typedef logic [IMG_COLS*PIX_W-1:0] row_t;

    typedef logic [$clog2(IMG_ROWS)-1:0] row_addr_t; // row index

endpackage
